/* logic/rename_settings.svh */
// sizing macros for the rename source table and its issue queue
// pull this in with `include wherever a depth, width or count is needed

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ===========================================================================
// queue and bundle sizing
// ===========================================================================

// number of issue queue entries, one tag per entry
`define QENTRIES 8

// instruction slots presented per bundle each cycle
`define QSLOTS 3

// ===========================================================================
// register file and tag sizing
// ===========================================================================

// architectural registers tracked by the source table
`define AREGS 32

// width of a queue tag, all three bits are used by eight entries
`define TAG_BITS 3

`endif

/* logic/isa_pkg.sv */
// architectural types seen by the front of the issue stage
// import with isa_pkg::* in the module header of any block that uses them

`include "rename_settings.svh"

`default_nettype none

package isa_pkg;

	// index of an architectural register
	typedef logic [$clog2(`AREGS)-1:0] areg_t;

	// opcode kind carried by a slot
	// only ALU and LOAD produce a register result
	typedef enum logic [2:0] {
		NOP    = 3'd0,
		ALU    = 3'd1,
		LOAD   = 3'd2,
		STORE  = 3'd3,
		BRANCH = 3'd4
	} slot_kind_e;

	// one slot of an incoming bundle, 9 bits wide
	typedef struct packed {
		logic       valid;
		slot_kind_e kind;
		areg_t      rd;
	} slot_t;

endpackage

`default_nettype wire

/* logic/queue_pkg.sv */
// queue-side types shared by the dispatch, the entries and the source table
// import with queue_pkg::* in the module header where they are needed

`include "rename_settings.svh"

`default_nettype none

package queue_pkg;

	// issue queue entry index, which doubles as the rename tag
	typedef logic [`TAG_BITS-1:0] qtag_t;

	// an entry is either free or holds an in-flight instruction
	typedef enum logic {
		EMPTY  = 1'b0,
		QUEUED = 1'b1
	} entry_state_e;

	// one source table slot
	// valid low means no writer is in flight for this register
	typedef struct packed {
		logic  valid;
		qtag_t tag;
	} src_t;

endpackage

`default_nettype wire

/* logic/rename_ifs.sv */
// bundles of signals passed between the dispatch, the queue entries and the table
// alloc_if carries the per-edge strobes and queue_state_if the per-entry state

`include "rename_settings.svh"

`default_nettype none

// ===========================================================================
// allocation, retire and squash strobes for the coming clock edge
// ===========================================================================
interface alloc_if
	import isa_pkg::*;
	import queue_pkg::*;
();

	logic [`QENTRIES-1:0] alloc_en;
	areg_t                alloc_rd [`QENTRIES];
	logic [`QENTRIES-1:0] alloc_wr;
	logic                 retire_en;
	logic [`QENTRIES-1:0] squash_mask;
	qtag_t                head;

	// the dispatch block drives every strobe
	modport source (output alloc_en, alloc_rd, alloc_wr, retire_en, squash_mask, head);

	// each entry picks out its own bit
	modport entry (input alloc_en, alloc_rd, alloc_wr, retire_en, squash_mask, head);

	// the table ignores squashes and waits for the rebuild instead
	modport tbl (input alloc_en, alloc_rd, alloc_wr, retire_en, head);

endinterface

// ===========================================================================
// registered queue state as seen by the source table
// ===========================================================================
interface queue_state_if
	import isa_pkg::*;
	import queue_pkg::*;
();

	entry_state_e state [`QENTRIES];
	areg_t        rd [`QENTRIES];
	logic         wr [`QENTRIES];
	qtag_t        head_tag;
	logic         rebuild;

	// every entry drives only its own index
	modport entry (output state, rd, wr);

	// dispatch owns the head and the miss register, and checks miss tags against state
	modport head (output head_tag, rebuild, input state);

	modport tbl (input state, rd, wr, head_tag, rebuild);

endinterface

`default_nettype wire

/* logic/slot_dispatch.sv */
// places bundle slots into free issue queue entries in order from the tail
// owns head, tail and occupancy and handles retire and branch miss moves
// drives the per-entry allocate strobes, the squash mask and the rebuild flag

`include "rename_settings.svh"

`default_nettype none

module slot_dispatch
	import isa_pkg::*;
	import queue_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire slot_t [`QSLOTS-1:0]  bundle,
	input  wire logic                 retire,
	input  wire logic                 branchmiss,
	input  wire qtag_t                miss_tag,
	output logic [1:0]                taken,
	output logic [3:0]                count,
	alloc_if.source                   alloc,
	queue_state_if.head               head_out
);

	localparam int unsigned depth = `QENTRIES;

	qtag_t      head_q;
	qtag_t      tail_q;
	logic [3:0] count_q;
	// high in the cycle after a miss, when the table rebuilds
	logic       miss_q;

	logic       blocked;
	logic       retire_ok;
	logic [3:0] free_slots;
	logic [1:0] n_take;
	qtag_t      miss_age;

	// a slot produces a register result only for ALU and LOAD kinds
	// writes to register 0 are dropped here so nothing downstream sees them
	function automatic logic writes_reg(input slot_t s);
		return (s.kind == ALU || s.kind == LOAD) && s.rd != '0;
	endfunction

	// no dispatch in the miss cycle or in the rebuild cycle after it
	assign blocked = branchmiss || miss_q;

	// retire on an empty queue is simply ignored
	assign retire_ok = retire && count_q != 4'd0;

	// free count taken before this cycle's retire so the head is never reused
	assign free_slots = 4'(depth) - count_q;

	// ===========================================================================
	// slot placement
	// ===========================================================================

	always_comb begin
		logic  stop;
		qtag_t slot_tag;
		stop = blocked;
		slot_tag = tail_q;
		n_take = 2'd0;
		alloc.alloc_en = '0;
		alloc.alloc_wr = '0;
		for (int e = 0; e < depth; e++) begin
			alloc.alloc_rd[e] = '0;
		end
		// walk the slots lowest first and skip the invalid ones
		// the first valid slot without room stops the rest of the bundle
		for (int s = 0; s < `QSLOTS; s++) begin
			if (bundle[s].valid && !stop) begin
				if ({2'b00, n_take} < free_slots) begin
					slot_tag = tail_q + qtag_t'(n_take);
					alloc.alloc_en[slot_tag] = 1'b1;
					alloc.alloc_rd[slot_tag] = bundle[s].rd;
					alloc.alloc_wr[slot_tag] = writes_reg(bundle[s]);
					n_take = n_take + 2'd1;
				end else begin
					stop = 1'b1;
				end
			end
		end
	end

	// ===========================================================================
	// squash mask on a branch miss
	// ===========================================================================

	// ages are measured from the head so the ring wrap needs no special case
	// an entry goes if it is younger than the miss and still inside the queue
	always_comb begin
		qtag_t age;
		miss_age = miss_tag - head_q;
		alloc.squash_mask = '0;
		for (int e = 0; e < depth; e++) begin
			age = qtag_t'(e) - head_q;
			if (branchmiss && age > miss_age && {1'b0, age} < count_q) begin
				alloc.squash_mask[e] = 1'b1;
			end
		end
	end

	// ===========================================================================
	// pointer and occupancy registers
	// ===========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= 4'd0;
			miss_q <= 1'b0;
		end else begin
			miss_q <= branchmiss;
			if (retire_ok) begin
				head_q <= head_q + qtag_t'(1);
			end
			// a miss keeps everything up to and including the mispredicted entry
			if (branchmiss) begin
				tail_q <= miss_tag + qtag_t'(1);
				count_q <= {1'b0, miss_age} + 4'd1;
			end else begin
				tail_q <= tail_q + qtag_t'(n_take);
				count_q <= count_q + {2'b00, n_take} - {3'b000, retire_ok};
			end
		end
	end

	assign alloc.retire_en = retire_ok;
	assign alloc.head = head_q;
	assign head_out.head_tag = head_q;
	assign head_out.rebuild = miss_q;
	assign taken = n_take;
	assign count = count_q;

	// occupancy can never run past the queue depth
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count_q <= 4'(depth))
		else $error("queue occupancy above depth");

	// a miss must name an instruction that is actually in the queue
	a_miss_queued: assert property (@(posedge clk) disable iff (rst)
		branchmiss |-> head_out.state[miss_tag] == QUEUED)
		else $error("branch miss on an empty entry");

	a_miss_retire: assert property (@(posedge clk) disable iff (rst)
		!(branchmiss && retire))
		else $error("branch miss and retire in the same cycle");

endmodule

`default_nettype wire

/* logic/iq_entry.sv */
// one issue queue entry holding its state, target register and writes bit
// instantiated once per entry, idx is the entry's own tag

`default_nettype none

module iq_entry
	import isa_pkg::*;
	import queue_pkg::*;
#(
	parameter int idx = 0
) (
	input  wire logic   clk,
	input  wire logic   rst,
	alloc_if.entry      alloc,
	queue_state_if.entry state
);

	localparam qtag_t my_tag = qtag_t'(idx);

	entry_state_e state_q;
	areg_t        rd_q;
	logic         wr_q;

	// leaving the queue happens on retire at the head or on a squash
	logic leave;

	assign leave = alloc.squash_mask[idx] || (alloc.retire_en && alloc.head == my_tag);

	// state machine between EMPTY and QUEUED
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= EMPTY;
		end else begin
			case (state_q)
				EMPTY: begin
					if (alloc.alloc_en[idx]) begin
						state_q <= QUEUED;
					end
				end
				QUEUED: begin
					if (leave) begin
						state_q <= EMPTY;
					end
				end
				default: state_q <= EMPTY;
			endcase
		end
	end

	// payload is only looked at while the entry is QUEUED
	always_ff @(posedge clk) begin
		if (alloc.alloc_en[idx]) begin
			rd_q <= alloc.alloc_rd[idx];
			wr_q <= alloc.alloc_wr[idx];
		end
	end

	assign state.state[idx] = state_q;
	assign state.rd[idx] = rd_q;
	assign state.wr[idx] = wr_q;

	// dispatch must only pick free entries
	a_alloc_free: assert property (@(posedge clk) disable iff (rst)
		alloc.alloc_en[idx] |-> state_q == EMPTY)
		else $error("entry %0d allocated while queued", idx);

endmodule

`default_nettype wire

/* logic/rename_source_table.sv */
// per-register source table naming the youngest in-flight writer of each register
// updated by dispatch and retire, rebuilt from the queue after a branch miss
// two combinational lookup ports read the registered table

`include "rename_settings.svh"

`default_nettype none

module rename_source_table
	import isa_pkg::*;
	import queue_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	alloc_if.tbl         alloc,
	queue_state_if.tbl   qstate,
	input  wire areg_t   rs_a,
	input  wire areg_t   rs_b,
	output src_t         src_a,
	output src_t         src_b
);

	src_t src_q [`AREGS];
	src_t src_d [`AREGS];

	// some valid tag points at a free entry
	logic stale;

	// ===========================================================================
	// next table value
	// ===========================================================================

	// the three updates are layered rebuild first, then retire, then dispatch
	always_comb begin
		qtag_t e;
		e = '0;
		for (int r = 0; r < `AREGS; r++) begin
			src_d[r] = src_q[r];
		end

		// rebuild from the surviving entries in age order from the head
		// younger writers come later in the scan and overwrite older ones
		if (qstate.rebuild) begin
			for (int r = 0; r < `AREGS; r++) begin
				src_d[r] = '0;
			end
			for (int k = 0; k < `QENTRIES; k++) begin
				e = qstate.head_tag + qtag_t'(k);
				if (qstate.state[e] == QUEUED && qstate.wr[e]) begin
					src_d[qstate.rd[e]] = '{valid: 1'b1, tag: e};
				end
			end
		end

		// the retiring head releases any register that still names it
		if (alloc.retire_en) begin
			for (int r = 0; r < `AREGS; r++) begin
				if (src_d[r].valid && src_d[r].tag == alloc.head) begin
					src_d[r] = '0;
				end
			end
		end

		// new writers land in age order, so a later slot wins on the same register
		// dispatch fills entries after the tail, which is also age order from the head
		for (int k = 0; k < `QENTRIES; k++) begin
			e = alloc.head + qtag_t'(k);
			if (alloc.alloc_en[e] && alloc.alloc_wr[e]) begin
				src_d[alloc.alloc_rd[e]] = '{valid: 1'b1, tag: e};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `AREGS; r++) begin
				src_q[r] <= '0;
			end
		end else begin
			for (int r = 0; r < `AREGS; r++) begin
				src_q[r] <= src_d[r];
			end
		end
	end

	// ===========================================================================
	// lookup ports and consistency check
	// ===========================================================================

	assign src_a = src_q[rs_a];
	assign src_b = src_q[rs_b];

	always_comb begin
		stale = 1'b0;
		for (int r = 0; r < `AREGS; r++) begin
			if (src_q[r].valid && qstate.state[src_q[r].tag] == EMPTY) begin
				stale = 1'b1;
			end
		end
	end

	// squashed writers linger only until the rebuild edge
	a_no_stale: assert property (@(posedge clk) disable iff (rst)
		!qstate.rebuild |-> !stale)
		else $error("source table names an empty entry");

endmodule

`default_nettype wire

/* logic/rename_top.sv */
// top of the rename source table block with plain ports
// joins dispatch, the eight queue entries and the table through the two interfaces

`include "rename_settings.svh"

`default_nettype none

module rename_top
	import isa_pkg::*;
	import queue_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire slot_t [`QSLOTS-1:0]  bundle,
	output logic [1:0]                taken,
	input  wire logic                 retire,
	input  wire logic                 branchmiss,
	input  wire qtag_t                miss_tag,
	input  wire areg_t                rs_a,
	input  wire areg_t                rs_b,
	output src_t                      src_a,
	output src_t                      src_b,
	output logic [3:0]                count
);

	alloc_if       alloc();
	queue_state_if qstate();

	slot_dispatch u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.bundle     (bundle),
		.retire     (retire),
		.branchmiss (branchmiss),
		.miss_tag   (miss_tag),
		.taken      (taken),
		.count      (count),
		.alloc      (alloc.source),
		.head_out   (qstate.head)
	);

	// one entry per tag, each driving its own slice of the queue state
	for (genvar g = 0; g < `QENTRIES; g++) begin : g_entry
		iq_entry #(
			.idx (g)
		) u_entry (
			.clk   (clk),
			.rst   (rst),
			.alloc (alloc.entry),
			.state (qstate.entry)
		);
	end

	rename_source_table u_table (
		.clk    (clk),
		.rst    (rst),
		.alloc  (alloc.tbl),
		.qstate (qstate.tbl),
		.rs_a   (rs_a),
		.rs_b   (rs_b),
		.src_a  (src_a),
		.src_b  (src_b)
	);

endmodule

`default_nettype wire

/* test/rename_checker.sv */
// scoreboard for the rename block, watching the ports of the UUT
// steps a model of the queue and table on each falling edge and compares outputs

`include "rename_settings.svh"

`default_nettype none

module rename_checker
	import isa_pkg::*;
	import queue_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire slot_t [`QSLOTS-1:0] bundle,
	input  wire logic                retire,
	input  wire logic                branchmiss,
	input  wire qtag_t               miss_tag,
	input  wire areg_t               rs_a,
	input  wire areg_t               rs_b,
	input  wire logic [1:0]          taken,
	input  wire src_t                src_a,
	input  wire src_t                src_b,
	input  wire logic [3:0]          count,
	input  var  int                  test_id,
	input  wire logic                test_end,
	input  wire logic                run_end,
	output int                       errors,
	output int                       model_count,
	output qtag_t                    model_head
);
	timeunit 1ns;
	timeprecision 1ps;

	// the model holds the DUT state as it will be after the coming edge
	entry_state_e m_state [`QENTRIES];
	areg_t        m_rd [`QENTRIES];
	logic         m_wr [`QENTRIES];
	src_t         m_tab [`AREGS];
	qtag_t        m_head;
	qtag_t        m_tail;
	int           m_count;
	logic         m_miss;
	int           n_errors = 0;
	int           checks = 0;
	int           errors_before = 0;
	int           tests_done = 0;

	assign errors = n_errors;
	assign model_count = m_count;
	assign model_head = m_head;

	function automatic logic is_writer(input slot_t s);
		return (s.kind == ALU || s.kind == LOAD) && s.rd != 5'd0;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "single slots";
			3: return "full bundle";
			4: return "queue full";
			5: return "retire release";
			6: return "random with misses";
			default: return "unnamed";
		endcase
	endfunction

	function automatic void reset_model();
		for (int e = 0; e < `QENTRIES; e++) begin
			m_state[e] = EMPTY;
			m_rd[e] = '0;
			m_wr[e] = 1'b0;
		end
		for (int r = 0; r < `AREGS; r++) begin
			m_tab[r] = '0;
		end
		m_head = '0;
		m_tail = '0;
		m_count = 0;
		m_miss = 1'b0;
	endfunction

	// ===========================================================================
	// reference model that steps one clock edge per call and returns the taken count
	// ===========================================================================

	function automatic int apply_cycle(input slot_t [`QSLOTS-1:0] b, input logic ret,
			input logic miss, input qtag_t mtag);
		src_t  nt [`AREGS];
		qtag_t e;
		qtag_t miss_age;
		int    n;
		int    kill;
		logic  stop;
		logic  ret_ok;
		n = 0;
		stop = miss || m_miss;
		ret_ok = ret && m_count != 0;
		for (int r = 0; r < `AREGS; r++) begin
			nt[r] = m_tab[r];
		end
		// the rebuild scans youngest first and keeps the first writer found for a register
		if (m_miss) begin
			for (int r = 0; r < `AREGS; r++) begin
				nt[r] = '0;
			end
			for (int k = `QENTRIES - 1; k >= 0; k--) begin
				e = m_head + qtag_t'(k);
				if (m_state[e] == QUEUED && m_wr[e] && !nt[m_rd[e]].valid) begin
					nt[m_rd[e]] = '{valid: 1'b1, tag: e};
				end
			end
		end
		if (ret_ok) begin
			for (int r = 0; r < `AREGS; r++) begin
				if (nt[r].valid && nt[r].tag == m_head) begin
					nt[r] = '0;
				end
			end
		end
		// free entries are counted before the retire and later slots overwrite earlier ones
		for (int s = 0; s < `QSLOTS; s++) begin
			if (b[s].valid && !stop) begin
				if (n < `QENTRIES - m_count) begin
					e = m_tail + qtag_t'(n);
					m_state[e] = QUEUED;
					m_rd[e] = b[s].rd;
					m_wr[e] = is_writer(b[s]);
					if (is_writer(b[s])) begin
						nt[b[s].rd] = '{valid: 1'b1, tag: e};
					end
					n++;
				end else begin
					stop = 1'b1;
				end
			end
		end
		if (ret_ok) begin
			m_state[m_head] = EMPTY;
		end
		// squash everything between the mispredicted entry and the tail
		if (miss) begin
			miss_age = mtag - m_head;
			kill = m_count - (int'(miss_age) + 1);
			for (int k = 1; k <= kill; k++) begin
				e = mtag + qtag_t'(k);
				m_state[e] = EMPTY;
			end
			m_tail = mtag + qtag_t'(1);
			m_count = int'(miss_age) + 1;
		end else begin
			m_tail = m_tail + qtag_t'(n);
			m_count = m_count + n - (ret_ok ? 1 : 0);
		end
		if (ret_ok) begin
			m_head = m_head + qtag_t'(1);
		end
		m_miss = miss;
		for (int r = 0; r < `AREGS; r++) begin
			m_tab[r] = nt[r];
		end
		return n;
	endfunction

	task automatic compare_value(input string sig, input logic [31:0] got, input int exp);
		checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED t=%0t %s got %0d expected %0d", $time, sig, got, exp);
		end
	endtask

	// the tag of an invalid entry carries no meaning
	task automatic compare_src(input string sig, input src_t got, input src_t exp);
		checks++;
		if (got.valid !== exp.valid || (exp.valid && got.tag !== exp.tag)) begin
			n_errors++;
			$display("FAILED t=%0t %s got valid=%0b tag=%0d expected valid=%0b tag=%0d",
				$time, sig, got.valid, got.tag, exp.valid, exp.tag);
		end
	endtask

	// inputs change on the rising edge, so everything is settled here
	always @(negedge clk) begin
		int exp_taken;
		if (rst) begin
			reset_model();
		end else begin
			compare_value("count", 32'(count), m_count);
			compare_src("src_a", src_a, m_tab[rs_a]);
			compare_src("src_b", src_b, m_tab[rs_b]);
			exp_taken = apply_cycle(bundle, retire, branchmiss, miss_tag);
			compare_value("taken", 32'(taken), exp_taken);
		end
		if (test_end) begin
			$display("test %0d (%s) finished with %0d errors", test_id, test_name(test_id),
				n_errors - errors_before);
			errors_before = n_errors;
			tests_done++;
		end
		if (run_end) begin
			$display("%0d tests, %0d checks, %0d errors", tests_done, checks, n_errors);
		end
	end

endmodule

`default_nettype wire

/* test/tb_rename.sv */
// testbench top for the rename source table block
// runs the directed tests and a seeded random run while rename_checker compares

`include "rename_settings.svh"

`default_nettype none

module tb_rename
	import isa_pkg::*;
	import queue_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam slot_t no_slot = '0;

	logic                clk;
	logic                rst;
	slot_t [`QSLOTS-1:0] bundle;
	logic                retire;
	logic                branchmiss;
	qtag_t               miss_tag;
	areg_t               rs_a;
	areg_t               rs_b;
	logic [1:0]          taken;
	src_t                src_a;
	src_t                src_b;
	logic [3:0]          count;
	int                  test_id;
	logic                test_end;
	logic                run_end;
	int                  errors;
	int                  model_count;
	qtag_t               model_head;
	int                  seed;
	int                  timeouts;
	int                  tries;
	int                  pending;
	int                  pick;
	slot_t               want [3];

	always #4 clk = ~clk;

	rename_top UUT (.*);

	rename_checker u_check (.*);

	function automatic slot_t make_slot(input slot_kind_e kind, input int rd);
		return '{valid: 1'b1, kind: kind, rd: areg_t'(rd)};
	endfunction

	// small register range so that random writers collide often
	function automatic slot_t random_slot();
		slot_t s;
		s.valid = ($random(seed) & 3) != 0;
		s.kind = slot_kind_e'(3'($unsigned($random(seed)) % 5));
		s.rd = areg_t'($unsigned($random(seed)) % 8);
		return s;
	endfunction

	task automatic present(input slot_t s0, input slot_t s1, input slot_t s2, input logic ret);
		@(posedge clk);
		bundle <= {s2, s1, s0};
		retire <= ret;
		branchmiss <= 1'b0;
	endtask

	task automatic lookup_idle(input int a, input int b);
		@(posedge clk);
		rs_a <= areg_t'(a);
		rs_b <= areg_t'(b);
		bundle <= '0;
		retire <= 1'b0;
		branchmiss <= 1'b0;
	endtask

	// test_end is high for one cycle while the checker prints the line for the test
	task automatic close_test(input int n);
		lookup_idle(0, 0);
		test_id <= n;
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timeouts++;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		bundle = '0;
		retire = 1'b0;
		branchmiss = 1'b0;
		miss_tag = '0;
		rs_a = '0;
		rs_b = '0;
		test_id = 0;
		test_end = 1'b0;
		run_end = 1'b0;
		seed = 18;
		timeouts = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// ===========================================================================
		// directed tests
		// ===========================================================================

		// every register looked up on both ports with nothing in flight
		for (int r = 0; r < `AREGS; r++) begin
			lookup_idle(r, `AREGS - 1 - r);
		end
		close_test(1);

		// one ALU slot per cycle, moving through slot positions 0, 1 and 2
		present(make_slot(ALU, 5), no_slot, no_slot, 1'b0);
		present(no_slot, make_slot(ALU, 6), no_slot, 1'b0);
		present(no_slot, no_slot, make_slot(ALU, 7), 1'b0);
		lookup_idle(5, 6);
		lookup_idle(7, 5);
		close_test(2);

		// same register twice in one bundle, a STORE, then a write to register 0
		present(make_slot(ALU, 9), make_slot(ALU, 9), make_slot(STORE, 10), 1'b0);
		present(make_slot(ALU, 0), no_slot, no_slot, 1'b0);
		lookup_idle(9, 10);
		lookup_idle(0, 9);
		close_test(3);

		// keep a full bundle on the input until the queue holds 8 entries
		want[0] = make_slot(ALU, 20);
		want[1] = make_slot(LOAD, 21);
		want[2] = make_slot(ALU, 22);
		tries = 0;
		while (count != 4'd8 && tries < 12) begin
			present(want[0], want[1], want[2], 1'b0);
			@(negedge clk);
			tries++;
		end
		if (count != 4'd8) begin
			note_timeout("queue did not fill within 12 cycles");
		end
		// upstream drops what was taken and moves the rest down to slot 0
		pending = 3;
		tries = 0;
		while (pending > 0 && tries < 12) begin
			present(want[3 - pending], pending > 1 ? want[4 - pending] : no_slot,
				pending > 2 ? want[2] : no_slot, 1'b1);
			@(negedge clk);
			pending = pending - int'(taken);
			tries++;
		end
		if (pending > 0) begin
			note_timeout("re-presented slots were not accepted within 12 cycles");
		end
		close_test(4);

		// drain the queue, then retire the only writer of r12
		// the second retire takes the older writer of r13 while a younger one stays
		tries = 0;
		while (count != 4'd0 && tries < 16) begin
			present(no_slot, no_slot, no_slot, 1'b1);
			@(negedge clk);
			tries++;
		end
		if (count != 4'd0) begin
			note_timeout("queue did not drain within 16 cycles");
		end
		present(make_slot(ALU, 12), make_slot(ALU, 13), no_slot, 1'b0);
		present(make_slot(LOAD, 13), no_slot, no_slot, 1'b0);
		lookup_idle(12, 13);
		present(no_slot, no_slot, no_slot, 1'b1);
		present(no_slot, no_slot, no_slot, 1'b1);
		lookup_idle(12, 13);
		lookup_idle(13, 12);
		close_test(5);

		// ===========================================================================
		// random bundles, retires and branch misses
		// ===========================================================================

		// the model's count and head name a queued entry for the miss at this edge
		for (int i = 0; i < 300; i++) begin
			@(posedge clk);
			pick = $unsigned($random(seed)) % 16;
			rs_a <= areg_t'($unsigned($random(seed)) % 8);
			rs_b <= areg_t'($unsigned($random(seed)) % 8);
			bundle <= {random_slot(), random_slot(), random_slot()};
			if (pick == 0 && model_count > 0) begin
				branchmiss <= 1'b1;
				retire <= 1'b0;
				miss_tag <= model_head + qtag_t'($unsigned($random(seed)) % model_count);
			end else begin
				branchmiss <= 1'b0;
				retire <= pick < 8;
			end
		end
		lookup_idle(1, 2);
		lookup_idle(3, 4);
		close_test(6);

		@(posedge clk);
		run_end <= 1'b1;
		@(posedge clk);
		run_end <= 1'b0;
		@(posedge clk);
		if (errors == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/isa_pkg.sv
logic/queue_pkg.sv
logic/rename_ifs.sv
logic/slot_dispatch.sv
logic/iq_entry.sv
logic/rename_source_table.sv
logic/rename_top.sv
test/rename_checker.sv
test/tb_rename.sv

/* Makefile */
TOOL  = verilator
TOP   = tb_rename
FLIST = verilog.f
FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) -o $(TOP)
	./$(OBJ)/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
